/* common/sync_config.svh */
// Build-time sizes for the lane aligner
// SYNC_SAMPLE_W must be even, since I and Q each take one half
// SYNC_FIFO_AW of 1 or more, so every lane FIFO has at least 2 entries
`ifndef SYNC_CONFIG_SVH
`define SYNC_CONFIG_SVH

// Number of lanes joined into one stream
`define SYNC_LANES 2

// Full I/Q sample word
`define SYNC_SAMPLE_W 32

// FIFO address width per lane
// Depth is 2**SYNC_FIFO_AW
`define SYNC_FIFO_AW 2

`endif

/* common/sample_pkg.sv */
// Sample word types shared by every lane
// I sits in the upper half and Q in the lower half, both two's complement
`include "sync_config.svh"

package sample_pkg;

  // Width of one I or Q component
  localparam int HALF_W = `SYNC_SAMPLE_W / 2;

  // Complex sample, I first so it lands in the upper bits
  typedef struct packed {
    logic signed [HALF_W-1:0] i;
    logic signed [HALF_W-1:0] q;
  } iq_t;

  // Same word seen as plain bits or as I/Q
  // Plumbing moves raw, arithmetic reads iq
  typedef union packed {
    logic [`SYNC_SAMPLE_W-1:0] raw;
    iq_t                       iq;
  } sample_t;

endpackage

/* common/stream_pkg.sv */
// Types for the per-lane stream plumbing
// Lane masks carry one bit per lane, bit n for lane n
`include "sync_config.svh"

package stream_pkg;

  // Valid, ready and last vectors across lanes
  typedef logic [`SYNC_LANES-1:0] lane_mask_t;

  // FIFO pointer with one wrap bit above the address
  // Equal addresses with different wrap bits means full
  typedef logic [`SYNC_FIFO_AW:0] fifo_ptr_t;

endpackage

/* lane_fifo/lane_fifo.sv */
// Single-lane circular FIFO, valid/ready on both sides
// Output valid one cycle after the write edge, no fall-through
// Full only at 2**SYNC_FIFO_AW stored words
// i_clear drops all stored words on the next edge
`include "sync_config.svh"

module lane_fifo (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_clear,
  input  sample_pkg::sample_t i_data,
  input  logic                i_last,
  input  logic                i_valid,
  output logic                o_ready,
  output sample_pkg::sample_t o_data,
  output logic                o_last,
  output logic                o_valid,
  input  logic                i_ready
);

  import stream_pkg::*;

  localparam int DEPTH = 1 << `SYNC_FIFO_AW;

  // Storage, data and last side by side
  logic [`SYNC_SAMPLE_W-1:0] mem_data [DEPTH];
  logic                      mem_last [DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // Same address, wrap bits differ -> full
  assign full = (wr_ptr[`SYNC_FIFO_AW] != rd_ptr[`SYNC_FIFO_AW]) &&
                (wr_ptr[`SYNC_FIFO_AW-1:0] == rd_ptr[`SYNC_FIFO_AW-1:0]);
  // Identical pointers -> empty
  assign empty = (wr_ptr == rd_ptr);

  assign push = i_valid && !full;
  assign pop  = !empty && i_ready;

  // Upstream side
  assign o_ready = !full;

  // Downstream side, head of queue straight from the array
  assign o_valid    = !empty;
  assign o_data.raw = mem_data[rd_ptr[`SYNC_FIFO_AW-1:0]];
  assign o_last     = mem_last[rd_ptr[`SYNC_FIFO_AW-1:0]];

  // Array write, contents need no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr[`SYNC_FIFO_AW-1:0]] <= i_data.raw;
      mem_last[wr_ptr[`SYNC_FIFO_AW-1:0]] <= i_last;
    end
  end

  // Pointer update
  // Clear wins over a push or pop in the same cycle
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= fifo_ptr_t'(wr_ptr + 1'b1);
      end
      if (pop) begin
        rd_ptr <= fifo_ptr_t'(rd_ptr + 1'b1);
      end
    end
  end

endmodule

/* design/lane_align.sv */
// Joins all lane FIFO heads into one transfer
// Release only when every lane is valid and downstream is ready
// Output valid follows i_ready here, so the sink's ready must not wait on valid
// Sticky mismatch flag on last-flag disagreement, cleared by i_clear
`include "sync_config.svh"

module lane_align (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  input  sample_pkg::sample_t    i_lane_data [`SYNC_LANES],
  input  stream_pkg::lane_mask_t i_lane_last,
  input  stream_pkg::lane_mask_t i_lane_valid,
  output stream_pkg::lane_mask_t o_lane_ready,
  output sample_pkg::sample_t    o_data [`SYNC_LANES],
  output logic                   o_last,
  output logic                   o_valid,
  input  logic                   i_ready,
  output logic                   o_last_mismatch
);

  import stream_pkg::*;

  logic release_set;
  logic last_split;
  logic mismatch_q;

  // One condition pops every lane at once
  assign release_set  = (&i_lane_valid) && i_ready;
  assign o_lane_ready = lane_mask_t'({`SYNC_LANES{release_set}});
  assign o_valid      = release_set;

  // Lane words pass through untouched, paired by position
  always_comb begin
    for (int n = 0; n < `SYNC_LANES; n++) begin
      o_data[n].raw = i_lane_data[n].raw;
    end
  end

  // Lane 0 is the reference for frame boundaries
  assign o_last = i_lane_last[0];

  // Some but not all lanes flag last
  assign last_split = (|i_lane_last) && !(&i_lane_last);

  // Sticky, only sampled on an actual release
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mismatch_q <= 1'b0;
    end else if (i_clear) begin
      mismatch_q <= 1'b0;
    end else if (release_set && last_split) begin
      mismatch_q <= 1'b1;
    end
  end

  assign o_last_mismatch = mismatch_q;

endmodule

/* design/iq_sum.sv */
// Lane-wise I/Q adder with signed saturation per half
// One output register, one item per cycle at full throughput
// Ready does not depend on i_valid
`include "sync_config.svh"

module iq_sum (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_clear,
  input  sample_pkg::sample_t i_data [`SYNC_LANES],
  input  logic                i_last,
  input  logic                i_valid,
  output logic                o_ready,
  output sample_pkg::sample_t o_sum,
  output logic                o_last,
  output logic                o_valid,
  input  logic                i_ready
);

  import sample_pkg::*;

  // Growth of log2(lanes) bits plus one spare
  localparam int SUM_W    = HALF_W + $clog2(`SYNC_LANES) + 1;
  localparam int HALF_MAX = (2 ** (HALF_W - 1)) - 1;
  localparam int HALF_MIN = -(2 ** (HALF_W - 1));

  logic signed [SUM_W-1:0] sum_i;
  logic signed [SUM_W-1:0] sum_q;
  sample_t                 sum_d;
  sample_t                 sum_q_reg;
  logic                    last_q;
  logic                    valid_q;
  logic                    load;

  // Clamp a wide sum back into one half
  function automatic logic signed [HALF_W-1:0] sat(input logic signed [SUM_W-1:0] v);
    logic signed [HALF_W-1:0] r;
    if (v > HALF_MAX) begin
      r = HALF_W'(HALF_MAX);
    end else if (v < HALF_MIN) begin
      r = HALF_W'(HALF_MIN);
    end else begin
      r = HALF_W'(v);
    end
    return r;
  endfunction

  // Sign-extended accumulation over lanes
  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int n = 0; n < `SYNC_LANES; n++) begin
      sum_i = sum_i + i_data[n].iq.i;
      sum_q = sum_q + i_data[n].iq.q;
    end
    sum_d.iq.i = sat(sum_i);
    sum_d.iq.q = sat(sum_q);
  end

  // Space when empty or being drained this cycle
  assign o_ready = !valid_q || i_ready;
  assign load    = i_valid && o_ready;

  // Payload, held while the output stalls
  always_ff @(posedge clk) begin
    if (load) begin
      sum_q_reg <= sum_d;
      last_q    <= i_last;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (i_clear) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  assign o_sum   = sum_q_reg;
  assign o_last  = last_q;
  assign o_valid = valid_q;

endmodule

/* design/iq_sync_top.sv */
// Multi-lane I/Q aligner and combiner
// o_valid two cycles after the last lane's write when unstalled
// Each lane buffers FIFO depth plus one sample before o_ready drops
`include "sync_config.svh"

module iq_sync_top (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  input  sample_pkg::sample_t    i_data [`SYNC_LANES],
  input  stream_pkg::lane_mask_t i_last,
  input  stream_pkg::lane_mask_t i_valid,
  output stream_pkg::lane_mask_t o_ready,
  output sample_pkg::sample_t    o_sum,
  output logic                   o_last,
  output logic                   o_valid,
  input  logic                   i_ready,
  output logic                   o_last_mismatch
);

  import sample_pkg::*;
  import stream_pkg::*;

  // FIFO heads
  sample_t    fifo_data [`SYNC_LANES];
  lane_mask_t fifo_last;
  lane_mask_t fifo_valid;
  lane_mask_t fifo_ready;

  // Joined transfer into the adder
  sample_t    al_data [`SYNC_LANES];
  logic       al_last;
  logic       al_valid;
  logic       sum_ready;

  // One buffer per lane absorbs the skew
  for (genvar g = 0; g < `SYNC_LANES; g++) begin : g_lane
    lane_fifo u_fifo (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_clear (i_clear),
      .i_data  (i_data[g]),
      .i_last  (i_last[g]),
      .i_valid (i_valid[g]),
      .o_ready (o_ready[g]),
      .o_data  (fifo_data[g]),
      .o_last  (fifo_last[g]),
      .o_valid (fifo_valid[g]),
      .i_ready (fifo_ready[g])
    );
  end

  lane_align u_align (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_clear         (i_clear),
    .i_lane_data     (fifo_data),
    .i_lane_last     (fifo_last),
    .i_lane_valid    (fifo_valid),
    .o_lane_ready    (fifo_ready),
    .o_data          (al_data),
    .o_last          (al_last),
    .o_valid         (al_valid),
    .i_ready         (sum_ready),
    .o_last_mismatch (o_last_mismatch)
  );

  iq_sum u_sum (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_data  (al_data),
    .i_last  (al_last),
    .i_valid (al_valid),
    .o_ready (sum_ready),
    .o_sum   (o_sum),
    .o_last  (o_last),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

endmodule

/* verification/iq_sync_checker.sv */
// Handshake assertions for the lane aligner top level
// Bound into iq_sync_top, reads the output handshake and the FIFO valids
module iq_sync_checker (
  input logic                   clk,
  input logic                   i_rst_n,
  input logic                   i_ready,
  input logic                   o_valid,
  input sample_pkg::sample_t    o_sum,
  input logic                   o_last,
  input stream_pkg::lane_mask_t fifo_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Output register stays empty while reset is held
  a_idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> !o_valid)
    else $error("o_valid high during reset");

  // Stalled output keeps its payload
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> ($stable(o_sum) && $stable(o_last)))
    else $error("o_sum or o_last changed while stalled");

  // A freshly loaded output needs every lane FIFO holding data one cycle before
  a_all_lanes: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_valid && !$past(o_valid && !i_ready)) |-> $past(&fifo_valid))
    else $error("output loaded while a lane FIFO was empty");

endmodule

bind iq_sync_top iq_sync_checker u_checker (
  .clk        (clk),
  .i_rst_n    (i_rst_n),
  .i_ready    (i_ready),
  .o_valid    (o_valid),
  .o_sum      (o_sum),
  .o_last     (o_last),
  .fifo_valid (fifo_valid)
);

/* verification/iq_sync_tb.sv */
// Directed testbench for iq_sync_top, lane count taken from the config header
// Inputs change 2 ns after the rising edge, outputs are read on the falling edge
`include "sync_config.svh"

module iq_sync_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import sample_pkg::*;
  import stream_pkg::*;

  // Reset plus six short tests, each well under 150 cycles, with margin
  localparam int CYCLE_LIMIT = 2000;

  logic clk;
  logic i_rst_n;
  logic i_clear;
  logic i_ready;
  sample_t i_data [`SYNC_LANES];
  lane_mask_t i_last;
  lane_mask_t i_valid;
  lane_mask_t o_ready;
  sample_t o_sum;
  logic o_last;
  logic o_valid;
  logic o_last_mismatch;

  // Pending lane inputs, expected and received outputs
  sample_t lane_data [`SYNC_LANES][$];
  bit lane_last [`SYNC_LANES][$];
  sample_t exp_sum[$];
  sample_t got_sum[$];
  bit exp_last[$];
  bit got_last[$];

  int acc_cnt [`SYNC_LANES];
  int out_cnt;
  int cycles;
  int errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  string test_name;

  iq_sync_top dut (.*);

  always #20 clk = ~clk;

  task automatic check_sum(input string name, input sample_t exp, input sample_t act);
    if (act.iq.i !== exp.iq.i || act.iq.q !== exp.iq.q) begin
      $display("FAILED %s expected i=%h q=%h actual i=%h q=%h",
               name, exp.iq.i, exp.iq.q, act.iq.i, act.iq.q);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Signed clamp to one I or Q half
  function automatic logic [HALF_W-1:0] clamp_half(input int v);
    int hi;
    hi = (1 << (HALF_W - 1)) - 1;
    if (v > hi) begin
      return HALF_W'(hi);
    end else if (v < -hi - 1) begin
      return HALF_W'(-hi - 1);
    end
    return HALF_W'(v);
  endfunction

  function automatic int min_accepted();
    int m;
    m = acc_cnt[0];
    for (int n = 1; n < `SYNC_LANES; n++) begin
      if (acc_cnt[n] < m) begin
        m = acc_cnt[n];
      end
    end
    return m;
  endfunction

  // One set across all lanes, expected result built alongside
  task automatic queue_set(input sample_t d [`SYNC_LANES], input lane_mask_t last);
    int si;
    int sq;
    sample_t e;
    si = 0;
    sq = 0;
    for (int n = 0; n < `SYNC_LANES; n++) begin
      lane_data[n].push_back(d[n]);
      lane_last[n].push_back(last[n]);
      si += int'(d[n].iq.i);
      sq += int'(d[n].iq.q);
    end
    e.iq.i = clamp_half(si);
    e.iq.q = clamp_half(sq);
    exp_sum.push_back(e);
    exp_last.push_back(last[0]);
  endtask

  task automatic queue_random_set(input lane_mask_t last);
    sample_t d [`SYNC_LANES];
    for (int n = 0; n < `SYNC_LANES; n++) begin
      d[n].raw = $urandom();
    end
    queue_set(d, last);
  endtask

  // Same I and Q on every lane
  task automatic queue_uniform(input int i, input int q);
    sample_t d [`SYNC_LANES];
    for (int n = 0; n < `SYNC_LANES; n++) begin
      d[n].iq.i = HALF_W'(i);
      d[n].iq.q = HALF_W'(q);
    end
    queue_set(d, '0);
  endtask

  // Lane n starts n*skew cycles late, gives up after limit cycles
  task automatic drive_lanes(input int skew, input int limit);
    int cyc;
    bit busy;
    lane_mask_t take;
    cyc = 0;
    busy = 1'b1;
    while (busy && cyc < limit) begin
      for (int n = 0; n < `SYNC_LANES; n++) begin
        i_valid[n] = (cyc >= n * skew) && (lane_data[n].size() > 0);
        if (i_valid[n]) begin
          i_data[n] = lane_data[n][0];
          i_last[n] = lane_last[n][0];
        end
      end
      @(negedge clk);
      take = i_valid & o_ready;
      @(posedge clk);
      #2;
      busy = 1'b0;
      for (int n = 0; n < `SYNC_LANES; n++) begin
        if (take[n]) begin
          void'(lane_data[n].pop_front());
          void'(lane_last[n].pop_front());
          acc_cnt[n]++;
        end
        if (lane_data[n].size() > 0) busy = 1'b1;
      end
      cyc++;
    end
    i_valid = '0;
    if (busy) begin
      $display("Lane input stalled, samples still pending after %0d cycles", limit);
      errors++;
    end
  endtask

  // Wait for every expected output, then compare in order
  task automatic check_outputs();
    int wait_cyc;
    wait_cyc = 0;
    while (got_sum.size() < exp_sum.size() && wait_cyc < 50) begin
      @(posedge clk);
      #2;
      wait_cyc++;
    end
    // Short margin so that surplus outputs show up too
    repeat (3) @(posedge clk);
    #2;
    if (got_sum.size() != exp_sum.size()) begin
      $display("Output count wrong, expected %0d samples but received %0d",
               exp_sum.size(), got_sum.size());
      errors++;
    end
    while (exp_sum.size() > 0 && got_sum.size() > 0) begin
      check_sum("o_sum", exp_sum.pop_front(), got_sum.pop_front());
      check_flag("o_last", exp_last.pop_front(), got_last.pop_front());
    end
    exp_sum.delete();
    exp_last.delete();
    got_sum.delete();
    got_last.delete();
  endtask

  task automatic check_mismatch(input logic exp);
    @(negedge clk);
    check_flag("o_last_mismatch", exp, o_last_mismatch);
    @(posedge clk);
    #2;
  endtask

  task automatic check_idle();
    @(negedge clk);
    check_flag("o_valid", 1'b0, o_valid);
    check_flag("o_last_mismatch", 1'b0, o_last_mismatch);
    for (int n = 0; n < `SYNC_LANES; n++) begin
      check_flag($sformatf("o_ready[%0d]", n), 1'b1, o_ready[n]);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic pulse_clear();
    i_clear = 1'b1;
    @(posedge clk);
    #2;
    i_clear = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark = errors;
    out_cnt = 0;
    for (int n = 0; n < `SYNC_LANES; n++) begin
      acc_cnt[n] = 0;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", test_name, errors - err_mark);
    end
  endtask

  task automatic test_reset_clear();
    start_test("reset and clear");
    check_idle();
    // Stall, load two sets with split last flags, then flush
    i_ready = 1'b0;
    queue_random_set(lane_mask_t'(1));
    queue_random_set('0);
    drive_lanes(0, 10);
    pulse_clear();
    exp_sum.delete();
    exp_last.delete();
    check_idle();
    i_ready = 1'b1;
    check_outputs();
    finish_test();
  endtask

  task automatic test_aligned();
    start_test("aligned random");
    repeat (8) queue_random_set('0);
    drive_lanes(0, 30);
    check_outputs();
    finish_test();
  endtask

  task automatic test_skew();
    start_test("skewed lanes");
    repeat (6) queue_random_set('0);
    drive_lanes(5, 60);
    check_outputs();
    finish_test();
  endtask

  task automatic test_saturation();
    start_test("saturation");
    queue_uniform(16'sh5000, -16'sh5000);
    queue_uniform(-16'sh4001, 16'sh3fff);
    queue_uniform(16'sh4000, -16'sh4000);
    queue_uniform(16'sh7fff, 16'sh0001);
    drive_lanes(0, 20);
    check_outputs();
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("back-pressure");
    i_ready = 1'b0;
    // Five sets must go in on consecutive cycles, then every lane is full
    repeat (5) queue_random_set('0);
    drive_lanes(0, 5);
    @(negedge clk);
    for (int n = 0; n < `SYNC_LANES; n++) begin
      check_flag($sformatf("o_ready[%0d]", n), 1'b0, o_ready[n]);
    end
    @(posedge clk);
    #2;
    i_ready = 1'b1;
    repeat (3) queue_random_set('0);
    drive_lanes(0, 20);
    check_outputs();
    finish_test();
  endtask

  task automatic test_last_flags();
    start_test("last flags");
    queue_random_set('0);
    queue_random_set('1);
    drive_lanes(0, 10);
    check_outputs();
    check_mismatch(1'b0);
    queue_random_set(lane_mask_t'(1));
    queue_random_set(~lane_mask_t'(1));
    drive_lanes(0, 10);
    check_outputs();
    check_mismatch(1'b1);
    queue_random_set('1);
    drive_lanes(0, 10);
    check_outputs();
    check_mismatch(1'b1);
    pulse_clear();
    check_mismatch(1'b0);
    finish_test();
  endtask

  // Output monitor that also checks nothing leaves before every lane wrote it
  always @(negedge clk) begin
    if (i_rst_n && o_valid) begin
      check_flag("o_valid after all lanes", 1'b1, (out_cnt + 1) <= min_accepted());
      if (i_ready) begin
        out_cnt++;
        got_sum.push_back(o_sum);
        got_last.push_back(o_last);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h80d4));
    clk = 1'b0;
    i_rst_n = 1'b0;
    i_clear = 1'b0;
    i_ready = 1'b1;
    i_valid = '0;
    i_last = '0;
    for (int n = 0; n < `SYNC_LANES; n++) begin
      i_data[n].raw = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    i_rst_n = 1'b1;
    test_reset_clear();
    test_aligned();
    test_skew();
    test_saturation();
    test_backpressure();
    test_last_flags();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/sample_pkg.sv
common/stream_pkg.sv
lane_fifo/lane_fifo.sv
design/lane_align.sv
design/iq_sum.sv
design/iq_sync_top.sv
verification/iq_sync_checker.sv
verification/iq_sync_tb.sv

/* Bender.yml */
package:
  name: iq_sync

export_include_dirs:
  - common

sources:
  - files:
      - common/sample_pkg.sv
      - common/stream_pkg.sv
      - lane_fifo/lane_fifo.sv
      - design/lane_align.sv
      - design/iq_sum.sv
      - design/iq_sync_top.sv
  - target: test
    files:
      - verification/iq_sync_checker.sv
      - verification/iq_sync_tb.sv
